// File: list.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_bank.sv
rtl/forward_unit.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/decode_top.sv
verif/decode_asserts.sv
verif/decode_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = decode_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } index($$0, "*** PASSED ***") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: verif/decode_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int WAIT_LIMIT = 20;

    logic      clock;
    logic      reset;
    logic      in_valid;
    instr_t    in_instr;
    addr_t     in_next_pc;
    logic      in_ready;
    logic      wb_write;
    reg_id_t   wb_dst;
    word_t     wb_value;
    logic      mem_reg_write;
    reg_id_t   mem_dst;
    word_t     mem_value;
    logic      redirect;
    addr_t     redirect_pc;
    logic      out_valid;
    alu_op_t   out_alu_op;
    logic      out_use_reg_b;
    logic      out_imm;
    word_t     out_ra_data;
    word_t     out_rb_data;
    reg_id_t   out_ra_id;
    reg_id_t   out_rb_id;
    reg_id_t   out_reg_dest;
    word_t     out_offset;
    logic      out_mem_read;
    logic      out_mem_write;
    mem_mode_t out_mem_mode;
    logic      out_reg_write;
    logic      offload;

    // Shadow register bank kept in step with the wb_ writes
    word_t  shadow [`NUM_REGS];
    integer seed;

    decode_top u_decode_top (.*);

    always #4 clock = ~clock;

    function automatic instr_t r_op(input opcode_t op, input reg_id_t d,
                                    input reg_id_t s1, input reg_id_t s2);
        return {op, d, s1, s2, 10'b0};
    endfunction

    function automatic instr_t m_op(input opcode_t op, input reg_id_t d,
                                    input reg_id_t s1, input m_offset_t off);
        return {op, d, s1, off};
    endfunction

    function automatic instr_t beq_op(input reg_id_t s1, input reg_id_t s2,
                                      input br_offset_t off);
        return {`ISA_BEQ_OP, off[14:10], s1, s2, off[9:0]};
    endfunction

    function automatic instr_t jump_op(input reg_id_t s1, input imm20_t off);
        return {`ISA_JUMP_OP, off[19:15], s1, off[14:10], off[9:0]};
    endfunction

    function automatic word_t sext15(input logic [14:0] v);
        return {{17{v[14]}}, v};
    endfunction

    function automatic word_t sext20(input logic [19:0] v);
        return {{12{v[19]}}, v};
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "decode_tb stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_controls(input logic v, input logic rd, input logic wr,
                                  input logic rw);
        check_value("out_valid", 32'(out_valid), 32'(v));
        check_value("out_mem_read", 32'(out_mem_read), 32'(rd));
        check_value("out_mem_write", 32'(out_mem_write), 32'(wr));
        check_value("out_reg_write", 32'(out_reg_write), 32'(rw));
    endtask

    task automatic check_stalls(input int stalls);
        assert (stalls == 1) else begin
            $display("Hazard held decode for %0d cycles instead of one", stalls);
            stop_run();
        end
    endtask

    task automatic write_reg(input reg_id_t id, input word_t value);
        @(posedge clock);
        wb_write <= 1'b1;
        wb_dst   <= id;
        wb_value <= value;
        @(posedge clock);
        wb_write <= 1'b0;
        if (id != '0) begin
            shadow[id] = value;
        end
    endtask

    task automatic drive(input instr_t instr, input addr_t npc);
        @(posedge clock);
        in_valid   <= 1'b1;
        in_instr   <= instr;
        in_next_pc <= npc;
    endtask

    // Called in the same time step as drive
    task automatic set_side(input logic mw, input reg_id_t md, input word_t mv,
                            input logic ww, input reg_id_t wd, input word_t wv);
        mem_reg_write <= mw;
        mem_dst       <= md;
        mem_value     <= mv;
        wb_write      <= ww;
        wb_dst        <= wd;
        wb_value      <= wv;
    endtask

    task automatic wait_ready(output int stalls);
        stalls = 0;
        @(negedge clock);
        while (!in_ready) begin
            if (stalls >= WAIT_LIMIT) begin
                $display("Timeout while waiting for in_ready after %0d cycles", stalls);
                stop_run();
            end else begin
                stalls++;
                @(negedge clock);
            end
        end
    endtask

    task automatic retire();
        @(posedge clock);
        in_valid      <= 1'b0;
        wb_write      <= 1'b0;
        mem_reg_write <= 1'b0;
        @(negedge clock);
    endtask

    task automatic issue(input instr_t instr, input addr_t npc);
        int stalls;
        drive(instr, npc);
        wait_ready(stalls);
        retire();
    endtask

    task automatic test_reg_rw();
        reg_id_t a;
        reg_id_t b;
        opcode_t op;
        for (int i = 1; i < `NUM_REGS; i++) begin
            write_reg(reg_id_t'(i), $random(seed));
        end
        write_reg('0, 32'hdead_beef);
        for (int i = 1; i < `NUM_REGS; i++) begin
            a  = reg_id_t'(i);
            b  = reg_id_t'(`NUM_REGS - i);
            op = `ISA_ADD_OP + opcode_t'(i % 4);
            issue(r_op(op, a, a, b), 32'h0);
            check_value("out_ra_data", out_ra_data, shadow[a]);
            check_value("out_rb_data", out_rb_data, shadow[b]);
            check_value("out_ra_id", 32'(out_ra_id), 32'(a));
            check_value("out_rb_id", 32'(out_rb_id), 32'(b));
            check_value("out_reg_dest", 32'(out_reg_dest), 32'(a));
            check_value("out_alu_op", 32'(out_alu_op), 32'(op[1:0]));
            check_value("out_use_reg_b", 32'(out_use_reg_b), 32'h1);
            check_controls(1'b1, 1'b0, 1'b0, 1'b1);
        end
        issue(r_op(`ISA_ADD_OP, 5'd1, 5'd0, 5'd0), 32'h0);
        check_value("out_ra_data", out_ra_data, 32'h0);
        check_value("out_rb_data", out_rb_data, 32'h0);
    endtask

    task automatic test_forwarding();
        int    stalls;
        word_t mem_v;
        word_t wb_v;
        mem_v = $random(seed);
        wb_v  = $random(seed);
        // Memory and writeback both target r7 and memory is younger
        drive(r_op(`ISA_ADD_OP, 5'd1, 5'd7, 5'd7), 32'h0);
        set_side(1'b1, 5'd7, mem_v, 1'b1, 5'd7, wb_v);
        wait_ready(stalls);
        retire();
        shadow[7] = wb_v;
        check_value("out_ra_data", out_ra_data, mem_v);
        check_value("out_rb_data", out_rb_data, mem_v);
        wb_v = $random(seed);
        drive(r_op(`ISA_ADD_OP, 5'd1, 5'd7, 5'd9), 32'h0);
        set_side(1'b1, 5'd8, mem_v, 1'b1, 5'd7, wb_v);
        wait_ready(stalls);
        retire();
        check_value("out_ra_data", out_ra_data, wb_v);
        check_value("out_rb_data", out_rb_data, shadow[9]);
        shadow[7] = wb_v;
        wb_v = $random(seed);
        drive(r_op(`ISA_ADD_OP, 5'd1, 5'd7, 5'd9), 32'h0);
        set_side(1'b1, 5'd8, mem_v, 1'b1, 5'd10, wb_v);
        wait_ready(stalls);
        retire();
        shadow[10] = wb_v;
        check_value("out_ra_data", out_ra_data, shadow[7]);
        check_value("out_rb_data", out_rb_data, shadow[9]);
    endtask

    task automatic test_mem_ops();
        issue(m_op(`ISA_LDW_OP, 5'd3, 5'd4, 15'h0010), 32'h0);
        check_controls(1'b1, 1'b1, 1'b0, 1'b1);
        check_value("out_offset", out_offset, sext15(15'h0010));
        check_value("out_mem_mode", 32'(out_mem_mode), 32'(WORD));
        check_value("out_ra_data", out_ra_data, shadow[4]);
        check_value("out_alu_op", 32'(out_alu_op), 32'(`ALU_ADD_OP));
        check_value("out_imm", 32'(out_imm), 32'h0);
        check_value("out_use_reg_b", 32'(out_use_reg_b), 32'h0);
        issue(m_op(`ISA_LDB_OP, 5'd3, 5'd4, 15'h7ff0), 32'h0);
        check_value("out_offset", out_offset, 32'hffff_fff0);
        check_value("out_mem_mode", 32'(out_mem_mode), 32'(BYTE));
        issue(m_op(`ISA_STW_OP, 5'd9, 5'd2, 15'h4001), 32'h0);
        check_controls(1'b1, 1'b0, 1'b1, 1'b0);
        check_value("out_offset", out_offset, sext15(15'h4001));
        check_value("out_rb_id", 32'(out_rb_id), 32'h9);
        check_value("out_rb_data", out_rb_data, shadow[9]);
        check_value("out_mem_mode", 32'(out_mem_mode), 32'(WORD));
        issue(m_op(`ISA_STB_OP, 5'd12, 5'd2, 15'h0003), 32'h0);
        check_value("out_rb_data", out_rb_data, shadow[12]);
        check_value("out_mem_mode", 32'(out_mem_mode), 32'(BYTE));
        issue({`ISA_LDI_OP, 5'd10, 20'h80005}, 32'h0);
        check_controls(1'b1, 1'b0, 1'b0, 1'b1);
        check_value("out_offset", out_offset, sext20(20'h80005));
        check_value("out_imm", 32'(out_imm), 32'h1);
        check_value("out_ra_data", out_ra_data, 32'h0);
        check_value("out_reg_dest", 32'(out_reg_dest), 32'ha);
    endtask

    task automatic branch_check(input instr_t instr, input addr_t npc,
                                input logic exp_taken, input addr_t exp_pc);
        int stalls;
        drive(instr, npc);
        wait_ready(stalls);
        check_value("redirect", 32'(redirect), 32'(exp_taken));
        if (exp_taken) begin
            check_value("redirect_pc", redirect_pc, exp_pc);
        end
        retire();
        check_controls(1'b1, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_branches();
        word_t base;
        base = $random(seed);
        write_reg(5'd11, base);
        write_reg(5'd12, base);
        write_reg(5'd13, base ^ 32'h1);
        branch_check(beq_op(5'd11, 5'd12, 15'h7ffe), 32'h100, 1'b1,
                     32'h100 + (sext15(15'h7ffe) << 2));
        branch_check(beq_op(5'd11, 5'd12, 15'h0005), 32'h200, 1'b1,
                     32'h200 + (sext15(15'h0005) << 2));
        branch_check(beq_op(5'd11, 5'd13, 15'h0005), 32'h200, 1'b0, 32'h0);
        branch_check(jump_op(5'd11, 20'hffff0), 32'h300, 1'b1, base + sext20(20'hffff0));
        branch_check(jump_op(5'd13, 20'h80000), 32'h300, 1'b1,
                     (base ^ 32'h1) + sext20(20'h80000));
    endtask

    task automatic test_hazards();
        int stalls;
        // Load to r5 then an ADD reading r5
        drive(m_op(`ISA_LDW_OP, 5'd5, 5'd1, 15'h0), 32'h0);
        wait_ready(stalls);
        drive(r_op(`ISA_ADD_OP, 5'd7, 5'd5, 5'd2), 32'h0);
        wait_ready(stalls);
        check_stalls(stalls);
        check_value("out_valid", 32'(out_valid), 32'h0);
        retire();
        check_controls(1'b1, 1'b0, 1'b0, 1'b1);
        check_value("out_ra_id", 32'(out_ra_id), 32'h5);
        check_value("out_reg_dest", 32'(out_reg_dest), 32'h7);
        check_value("out_ra_data", out_ra_data, shadow[5]);
        // Register write in execute then a BEQ on that register
        drive(r_op(`ISA_ADD_OP, 5'd6, 5'd1, 5'd2), 32'h0);
        wait_ready(stalls);
        drive(beq_op(5'd6, 5'd6, 15'h0004), 32'h400);
        wait_ready(stalls);
        check_stalls(stalls);
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("redirect", 32'(redirect), 32'h1);
        check_value("redirect_pc", redirect_pc, 32'h400 + (sext15(15'h0004) << 2));
        retire();
        check_controls(1'b1, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_stop();
        check_value("offload", 32'(offload), 32'h0);
        issue({`ISA_STOP_OP, 25'b0}, 32'h0);
        check_value("offload", 32'(offload), 32'h1);
        check_controls(1'b1, 1'b0, 1'b0, 1'b0);
        issue(r_op(`ISA_ADD_OP, 5'd2, 5'd3, 5'd4), 32'h0);
        check_value("offload", 32'(offload), 32'h1);
    endtask

    initial begin
        seed          = 32'h1830;
        clock         = 1'b0;
        reset         <= 1'b1;
        in_valid      <= 1'b0;
        in_instr      <= '0;
        in_next_pc    <= '0;
        wb_write      <= 1'b0;
        wb_dst        <= '0;
        wb_value      <= '0;
        mem_reg_write <= 1'b0;
        mem_dst       <= '0;
        mem_value     <= '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_controls(1'b0, 1'b0, 1'b0, 1'b0);
        check_value("offload", 32'(offload), 32'h0);
        check_value("redirect", 32'(redirect), 32'h0);
        test_reg_rw();
        test_forwarding();
        test_mem_ops();
        test_branches();
        test_hazards();
        test_stop();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verif/decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts (
    input logic clock,
    input logic reset,
    input logic in_valid,
    input logic stall,
    input logic redirect,
    input logic out_valid,
    input logic out_mem_read,
    input logic out_mem_write,
    input logic offload
);

    mem_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(out_mem_read && out_mem_write))
        else $error("out_mem_read and out_mem_write high together");

    // A stalled cycle always issues a bubble
    bubble_after_stall: assert property (@(posedge clock) disable iff (reset)
        stall |=> !out_valid)
        else $error("out_valid high in the cycle after stall");

    offload_sticky: assert property (@(posedge clock) disable iff (reset)
        offload |=> offload)
        else $error("offload fell while out of reset");

    redirect_needs_valid: assert property (@(posedge clock) disable iff (reset)
        !in_valid |-> !redirect)
        else $error("redirect high without in_valid");

endmodule

bind decode_top decode_asserts u_asserts (
    .clock         (clock),
    .reset         (reset),
    .in_valid      (in_valid),
    .stall         (stall),
    .redirect      (redirect),
    .out_valid     (out_valid),
    .out_mem_read  (out_mem_read),
    .out_mem_write (out_mem_write),
    .offload       (offload)
);

// File: rtl/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    input  isa_pkg::instr_t     in_instr,
    input  pipe_pkg::addr_t     in_next_pc,
    output logic                in_ready,
    input  logic                wb_write,
    input  isa_pkg::reg_id_t    wb_dst,
    input  pipe_pkg::word_t     wb_value,
    input  logic                mem_reg_write,
    input  isa_pkg::reg_id_t    mem_dst,
    input  pipe_pkg::word_t     mem_value,
    output logic                redirect,
    output pipe_pkg::addr_t     redirect_pc,
    output logic                out_valid,
    output pipe_pkg::alu_op_t   out_alu_op,
    output logic                out_use_reg_b,
    output logic                out_imm,
    output pipe_pkg::word_t     out_ra_data,
    output pipe_pkg::word_t     out_rb_data,
    output isa_pkg::reg_id_t    out_ra_id,
    output isa_pkg::reg_id_t    out_rb_id,
    output isa_pkg::reg_id_t    out_reg_dest,
    output pipe_pkg::word_t     out_offset,
    output logic                out_mem_read,
    output logic                out_mem_write,
    output pipe_pkg::mem_mode_t out_mem_mode,
    output logic                out_reg_write,
    output logic                offload
);

    isa_pkg::reg_id_t  bank_id_a;
    isa_pkg::reg_id_t  bank_id_b;
    pipe_pkg::word_t   bank_data_a;
    pipe_pkg::word_t   bank_data_b;
    pipe_pkg::bypass_t ra_bypass;
    pipe_pkg::bypass_t rb_bypass;
    logic              ra_use;
    logic              rb_use;
    logic              rd_use;
    logic              is_branch;
    logic              stall;

    reg_bank u_bank (
        .clock        (clock),
        .reset        (reset),
        .read_id_a    (bank_id_a),
        .read_id_b    (bank_id_b),
        .read_data_a  (bank_data_a),
        .read_data_b  (bank_data_b),
        .write_enable (wb_write),
        .write_id     (wb_dst),
        .write_data   (wb_value)
    );

    forward_unit u_fwd (
        .ra_id         (bank_id_a),
        .rb_id         (bank_id_b),
        .mem_reg_write (mem_reg_write),
        .mem_dst       (mem_dst),
        .wb_write      (wb_write),
        .wb_dst        (wb_dst),
        .ra_bypass     (ra_bypass),
        .rb_bypass     (rb_bypass)
    );

    // rd_id is the dst field, read only by stores
    hazard_unit u_hdu (
        .ra_id        (bank_id_a),
        .rb_id        (bank_id_b),
        .rd_id        (in_instr[24:20]),
        .ra_use       (ra_use),
        .rb_use       (rb_use),
        .rd_use       (rd_use),
        .is_branch    (is_branch),
        .ex_valid     (out_valid),
        .ex_mem_read  (out_mem_read),
        .ex_reg_write (out_reg_write),
        .ex_dst       (out_reg_dest),
        .stall        (stall)
    );

    decode_stage u_decode (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_next_pc    (in_next_pc),
        .in_ready      (in_ready),
        .bank_data_a   (bank_data_a),
        .bank_data_b   (bank_data_b),
        .bank_id_a     (bank_id_a),
        .bank_id_b     (bank_id_b),
        .ra_bypass     (ra_bypass),
        .rb_bypass     (rb_bypass),
        .mem_value     (mem_value),
        .wb_value      (wb_value),
        .stall         (stall),
        .ra_use        (ra_use),
        .rb_use        (rb_use),
        .rd_use        (rd_use),
        .is_branch     (is_branch),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .out_valid     (out_valid),
        .out_alu_op    (out_alu_op),
        .out_use_reg_b (out_use_reg_b),
        .out_imm       (out_imm),
        .out_ra_data   (out_ra_data),
        .out_rb_data   (out_rb_data),
        .out_ra_id     (out_ra_id),
        .out_rb_id     (out_rb_id),
        .out_reg_dest  (out_reg_dest),
        .out_offset    (out_offset),
        .out_mem_read  (out_mem_read),
        .out_mem_write (out_mem_write),
        .out_mem_mode  (out_mem_mode),
        .out_reg_write (out_reg_write),
        .offload       (offload)
    );

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      in_valid,
    input  instr_t    in_instr,
    input  addr_t     in_next_pc,
    output logic      in_ready,
    input  word_t     bank_data_a,
    input  word_t     bank_data_b,
    output reg_id_t   bank_id_a,
    output reg_id_t   bank_id_b,
    input  bypass_t   ra_bypass,
    input  bypass_t   rb_bypass,
    input  word_t     mem_value,
    input  word_t     wb_value,
    input  logic      stall,
    output logic      ra_use,
    output logic      rb_use,
    output logic      rd_use,
    output logic      is_branch,
    output logic      redirect,
    output addr_t     redirect_pc,
    output logic      out_valid,
    output alu_op_t   out_alu_op,
    output logic      out_use_reg_b,
    output logic      out_imm,
    output word_t     out_ra_data,
    output word_t     out_rb_data,
    output reg_id_t   out_ra_id,
    output reg_id_t   out_rb_id,
    output reg_id_t   out_reg_dest,
    output word_t     out_offset,
    output logic      out_mem_read,
    output logic      out_mem_write,
    output mem_mode_t out_mem_mode,
    output logic      out_reg_write,
    output logic      offload
);

    opcode_t    opcode;
    iclass_t    iclass;
    reg_id_t    f_dst;
    reg_id_t    f_src1;
    reg_id_t    f_src2;
    m_offset_t  m_offset;
    imm20_t     ldi_imm;
    imm20_t     jmp_offset;
    br_offset_t beq_offset;
    logic       is_rtype;
    logic       is_load;
    logic       is_store;
    logic       is_ldi;
    logic       is_beq;
    logic       is_jump;
    logic       is_stop;
    logic       accept;
    word_t      ra_value;
    word_t      rb_value;

    assign opcode = in_instr[31:25];
    assign iclass = in_instr[31:29];
    assign f_dst  = in_instr[24:20];
    assign f_src1 = in_instr[19:15];
    assign f_src2 = in_instr[14:10];

    assign m_offset   = in_instr[14:0];
    assign ldi_imm    = in_instr[19:0];
    assign jmp_offset = {in_instr[24:20], in_instr[14:10], in_instr[9:0]};
    assign beq_offset = {in_instr[24:20], in_instr[9:0]};

    assign is_rtype = (iclass == `R_TYPE_OP);
    assign is_load  = (opcode == `ISA_LDB_OP) || (opcode == `ISA_LDW_OP);
    assign is_store = (opcode == `ISA_STB_OP) || (opcode == `ISA_STW_OP);
    assign is_ldi   = (opcode == `ISA_LDI_OP);
    assign is_beq   = (opcode == `ISA_BEQ_OP);
    assign is_jump  = (opcode == `ISA_JUMP_OP);
    assign is_stop  = (opcode == `ISA_STOP_OP);

    assign accept   = in_valid && !stall;
    assign in_ready = !stall;

    // Stores read their data register through port b
    assign bank_id_a = f_src1;
    assign bank_id_b = is_store ? f_dst : f_src2;

    assign ra_use    = in_valid && (is_rtype || is_load || is_store || is_beq || is_jump);
    assign rb_use    = in_valid && (is_rtype || is_beq);
    assign rd_use    = in_valid && is_store;
    assign is_branch = in_valid && (is_beq || is_jump);

    always_comb begin
        case (ra_bypass)
            BYP_MEM: ra_value = mem_value;
            BYP_WB:  ra_value = wb_value;
            default: ra_value = bank_data_a;
        endcase
        case (rb_bypass)
            BYP_MEM: rb_value = mem_value;
            BYP_WB:  rb_value = wb_value;
            default: rb_value = bank_data_b;
        endcase
    end

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = in_next_pc;
        if (accept && is_jump) begin
            redirect    = 1'b1;
            redirect_pc = ra_value + addr_t'(signed'(jmp_offset));
        end else if (accept && is_beq && ra_value == rb_value) begin
            redirect    = 1'b1;
            redirect_pc = in_next_pc + (addr_t'(signed'(beq_offset)) << 2);
        end
    end

    // Control half of the issue register loads a bubble on stall
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid     <= 1'b0;
            out_mem_read  <= 1'b0;
            out_mem_write <= 1'b0;
            out_reg_write <= 1'b0;
            offload       <= 1'b0;
        end else begin
            out_valid     <= accept;
            out_mem_read  <= accept && is_load;
            out_mem_write <= accept && is_store;
            out_reg_write <= accept && (is_rtype || is_load || is_ldi);
            if (accept && is_stop) begin
                offload <= 1'b1;
            end
        end
    end

    // Payload half
    always_ff @(posedge clock) begin
        if (accept) begin
            out_alu_op    <= is_rtype ? alu_op_t'(opcode[1:0]) : `ALU_ADD_OP;
            out_use_reg_b <= is_rtype;
            out_imm       <= is_ldi;
            out_ra_data   <= is_ldi ? '0 : ra_value;
            out_rb_data   <= rb_value;
            out_ra_id     <= bank_id_a;
            out_rb_id     <= bank_id_b;
            out_reg_dest  <= f_dst;
            out_offset    <= is_ldi ? word_t'(signed'(ldi_imm)) : word_t'(signed'(m_offset));
            out_mem_mode  <= (opcode == `ISA_LDW_OP || opcode == `ISA_STW_OP) ? WORD : BYTE;
        end
    end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import isa_pkg::*;
(
    input  reg_id_t ra_id,
    input  reg_id_t rb_id,
    input  reg_id_t rd_id,
    input  logic    ra_use,
    input  logic    rb_use,
    input  logic    rd_use,
    input  logic    is_branch,
    input  logic    ex_valid,
    input  logic    ex_mem_read,
    input  logic    ex_reg_write,
    input  reg_id_t ex_dst,
    output logic    stall
);

    logic ra_hit;
    logic rb_hit;
    logic rd_hit;
    logic load_use;
    logic branch_wait;

    always_comb begin
        ra_hit = ra_use && ra_id == ex_dst;
        rb_hit = rb_use && rb_id == ex_dst;
        rd_hit = rd_use && rd_id == ex_dst;

        load_use = ex_valid && ex_mem_read && ex_dst != '0
                   && (ra_hit || rb_hit || rd_hit);

        // Execute results come too late for a branch compared in decode
        branch_wait = is_branch && ex_valid && ex_reg_write && ex_dst != '0
                      && (ra_hit || rb_hit);

        stall = load_use || branch_wait;
    end

endmodule

// File: rtl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  reg_id_t ra_id,
    input  reg_id_t rb_id,
    input  logic    mem_reg_write,
    input  reg_id_t mem_dst,
    input  logic    wb_write,
    input  reg_id_t wb_dst,
    output bypass_t ra_bypass,
    output bypass_t rb_bypass
);

    // Memory stage holds the younger value, so it is checked first
    function automatic bypass_t pick_source(input reg_id_t id);
        bypass_t src;
        src = BYP_BANK;
        if (id != '0) begin
            if (mem_reg_write && mem_dst == id) begin
                src = BYP_MEM;
            end else if (wb_write && wb_dst == id) begin
                src = BYP_WB;
            end
        end
        return src;
    endfunction

    always_comb begin
        ra_bypass = pick_source(ra_id);
        rb_bypass = pick_source(rb_id);
    end

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_bank
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  reg_id_t read_id_a,
    input  reg_id_t read_id_b,
    output word_t   read_data_a,
    output word_t   read_data_b,
    input  logic    write_enable,
    input  reg_id_t write_id,
    input  word_t   write_data
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_id != '0) begin
            regs[write_id] <= write_data;
        end
    end

    // r0 is hardwired to zero
    assign read_data_a = (read_id_a == '0) ? '0 : regs[read_id_a];
    assign read_data_b = (read_id_b == '0) ? '0 : regs[read_id_b];

endmodule

// File: rtl/pipe_pkg.sv
`include "cpu_consts.svh"

package pipe_pkg;

    typedef logic [`REG_WIDTH-1:0] word_t;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    typedef logic [1:0] alu_op_t;

    typedef enum logic {
        BYTE,
        WORD
    } mem_mode_t;

    // Operand source in decode
    typedef enum logic [1:0] {
        BYP_BANK,
        BYP_WB,
        BYP_MEM
    } bypass_t;

endpackage

// File: rtl/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

    // Full instruction word
    typedef logic [31:0] instr_t;

    // Bits 31 to 25
    typedef logic [6:0] opcode_t;

    // Bits 31 to 29
    typedef logic [2:0] iclass_t;

    typedef logic [`REG_ID_WIDTH-1:0] reg_id_t;

    // M-type offset in bits 14 to 0
    typedef logic [14:0] m_offset_t;

    // LDI immediate and the joined JUMP offset
    typedef logic [19:0] imm20_t;

    // BEQ offset made of offset_high and offset_low
    typedef logic [14:0] br_offset_t;

    // Field layout
    //   dst 24:20, src1 19:15, src2 14:10
    //   B-type offset_high 24:20, src1 19:15, src2_offset_m 14:10,
    //   offset_low 9:0

endpackage

// File: rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define REG_WIDTH    32
`define REG_ID_WIDTH 5
`define ADDR_WIDTH   32
`define NUM_REGS     32

// Instruction classes in opcode bits 6 to 4
`define R_TYPE_OP 3'b000
`define M_TYPE_OP 3'b001
`define B_TYPE_OP 3'b010

// R-type ops take the ALU op from the low two bits
`define ISA_ADD_OP  7'b000_0000
`define ISA_SUB_OP  7'b000_0001
`define ISA_AND_OP  7'b000_0010
`define ISA_OR_OP   7'b000_0011

`define ISA_LDB_OP  7'b001_0000
`define ISA_LDW_OP  7'b001_0001
`define ISA_STB_OP  7'b001_0010
`define ISA_STW_OP  7'b001_0011
`define ISA_LDI_OP  7'b001_0100

`define ISA_BEQ_OP  7'b010_0000
`define ISA_JUMP_OP 7'b010_0001
`define ISA_STOP_OP 7'b010_1111

`define ALU_ADD_OP  2'b00

`endif
